// File: rtl/cdc_pkg.sv
// ############################
// Lane geometry is fixed here; the RAM depth comes from ADDR_W in the top level
// ############################

package cdc_pkg;

    // ############################
    // Lane geometry
    // ############################

    localparam int LANES  = 8;               // Lanes per beat
    localparam int LANE_W = 65;              // Bits per lane
    localparam int BEAT_W = LANES * LANE_W;  // 520 bit beat

    // One lane word as held in a lane RAM
    typedef logic [LANE_W-1:0] lane_word_t;

    // ############################
    // Beat structs
    // ############################

    // Write side beat with lane 0 as the low lane
    typedef struct packed {
        logic                   valid;
        lane_word_t [LANES-1:0] data;
    } w_beat_t;

    // Read side beat with one valid bit per lane
    typedef struct packed {
        logic       [LANES-1:0] valid;
        lane_word_t [LANES-1:0] data;
    } r_beat_t;

endpackage

// File: rtl/wr_front.sv
// ############################
// Reset reaches this domain 3 write clocks late; without a stall every valid beat is taken
// ############################

module wr_front #(
    parameter int ADDR_W = 5
) (
    input  logic                                        i_clk_w,
    input  logic                                        i_reset_async,
    input  cdc_pkg::w_beat_t                            i_wr,
    output cdc_pkg::lane_word_t [cdc_pkg::LANES-1:0]    o_wdata,
    output logic                [ADDR_W-1:0]            o_waddr,
    output logic                [ADDR_W-1:0]            o_wptr
);

    logic [2:0]                  w_reset_sync;  // Reset synchronizer chain
    logic                        w_reset;
    logic [cdc_pkg::BEAT_W-1:0]  wdata_q;       // Registered beat payload
    logic                        wvalid_q;

    // ############################
    // Reset into the write domain
    // ############################

    always_ff @(posedge i_clk_w) begin
        w_reset_sync <= {w_reset_sync[1:0], i_reset_async};
    end

    assign w_reset = w_reset_sync[2];

    // ############################
    // Beat register and pointers
    // ############################

    always_ff @(posedge i_clk_w) begin
        wdata_q <= i_wr.data;
    end

    // The RAM address and the crossing pointer are kept as separate copies
    // so each one only drives its own fanout
    always_ff @(posedge i_clk_w) begin
        if (w_reset) begin
            wvalid_q <= 1'b0;
            o_waddr  <= '0;
            o_wptr   <= '0;
        end else begin
            wvalid_q <= i_wr.valid;
            if (wvalid_q) begin
                o_waddr <= o_waddr + 1'b1;  // Slot just written becomes readable
                o_wptr  <= o_wptr + 1'b1;
            end
        end
    end

    assign o_wdata = wdata_q;

    a_wptr_hold: assert property (@(posedge i_clk_w)
        w_reset ##1 w_reset |=> $stable(o_wptr))
        else $error("write pointer moved while write reset was held");

endmodule

// File: rtl/lane_ram.sv
// ############################
// Written on every write clock; async read, so only slots below the write pointer are valid
// ############################

module lane_ram #(
    parameter int  ADDR_W = 5,
    parameter type T      = cdc_pkg::lane_word_t
) (
    input  logic              i_clk_w,
    input  logic [ADDR_W-1:0] i_waddr,
    input  T                  i_wdata,
    input  logic [ADDR_W-1:0] i_raddr,
    output T                  o_rdata
);

    localparam int DEPTH = 2 ** ADDR_W;

    T mem [DEPTH];  // Small distributed memory

    // ############################
    // Write port
    // ############################

    // Without a write enable the slot at the write address only becomes visible
    // to the reader once the write pointer moves past it, so idle cycles
    // simply rewrite the same slot with the registered beat
    always_ff @(posedge i_clk_w) begin
        mem[i_waddr] <= i_wdata;
    end

    // ############################
    // Read port
    // ############################

    assign o_rdata = mem[i_raddr];  // Unregistered, sampled in read domain

endmodule

// File: rtl/gray_ptr_sync.sv
// ############################
// Input must step by at most one per write clock; reset only before traffic starts
// ############################

module gray_ptr_sync #(
    parameter int ADDR_W = 5
) (
    input  logic              i_clk_w,
    input  logic [ADDR_W-1:0] i_ptr,
    input  logic              i_clk_r,
    output logic [ADDR_W-1:0] o_ptr
);

    logic [ADDR_W-1:0] gray_w;   // Launch register, write domain
    logic [ADDR_W-1:0] gray_s1;  // First capture flop
    logic [ADDR_W-1:0] gray_s2;

    function automatic logic [ADDR_W-1:0] gray_to_bin(input logic [ADDR_W-1:0] g);
        logic [ADDR_W-1:0] b;
        b[ADDR_W-1] = g[ADDR_W-1];
        for (int i = ADDR_W - 2; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    // ############################
    // Write domain
    // ############################

    always_ff @(posedge i_clk_w) begin
        gray_w <= i_ptr ^ (i_ptr >> 1);
    end

    // ############################
    // Read domain
    // ############################

    always_ff @(posedge i_clk_r) begin
        gray_s1 <= gray_w;
        gray_s2 <= gray_s1;
    end

    assign o_ptr = gray_to_bin(gray_s2);

    // Only one bit may be in flight across the boundary at a time
    a_gray_step: assert property (@(posedge i_clk_w)
        !$isunknown($past(gray_w)) |-> $countones(gray_w ^ $past(gray_w)) <= 1)
        else $error("Gray pointer changed in more than one bit");

endmodule

// File: rtl/rd_lane_ctrl.sv
// ############################
// Lanes run replicated pointers that always agree; data is valid only where valid is high
// ############################

module rd_lane_ctrl #(
    parameter int ADDR_W = 5
) (
    input  logic                                        i_clk_r,
    input  logic                                        r_reset,
    input  logic                [ADDR_W-1:0]            i_wptr_sync,
    input  cdc_pkg::lane_word_t [cdc_pkg::LANES-1:0]    i_rdata,
    output logic [cdc_pkg::LANES-1:0][ADDR_W-1:0]       o_raddr,
    output cdc_pkg::r_beat_t                            o_rd
);

    logic [cdc_pkg::LANES-1:0][ADDR_W-1:0]       wptr_q;   // One copy per lane
    logic [cdc_pkg::LANES-1:0][ADDR_W-1:0]       rptr;
    logic [cdc_pkg::LANES-1:0]                   valid_q;
    cdc_pkg::lane_word_t [cdc_pkg::LANES-1:0]    data_q;

    // ############################
    // Per lane pointers
    // ############################

    always_ff @(posedge i_clk_r) begin
        for (int lane = 0; lane < cdc_pkg::LANES; lane++) begin
            if (r_reset) begin
                wptr_q[lane]  <= '0;
                rptr[lane]    <= '0;
                valid_q[lane] <= 1'b0;
            end else begin
                wptr_q[lane] <= i_wptr_sync;
                if (rptr[lane] != wptr_q[lane]) begin
                    rptr[lane]    <= rptr[lane] + 1'b1;  // Entry read this edge
                    valid_q[lane] <= 1'b1;
                end else begin
                    valid_q[lane] <= 1'b0;
                end
            end
        end
    end

    assign o_raddr = rptr;

    // ############################
    // Output beat
    // ############################

    // Sampled on the same edge that raises valid, so data lines up
    always_ff @(posedge i_clk_r) begin
        data_q <= i_rdata;
    end

    assign o_rd.valid = valid_q;
    assign o_rd.data  = data_q;

    a_lanes_agree: assert property (@(posedge i_clk_r) disable iff (r_reset)
        (valid_q == '0) || (valid_q == '1))
        else $error("lane valid bits disagree");

endmodule

// File: rtl/cdc_data_sync.sv
// ############################
// Without back-pressure the writer must stay under 2**ADDR_W-1 entries ahead of the reader
// ############################

module cdc_data_sync #(
    parameter int ADDR_W = 5
) (
    input  logic              i_clk_w,
    input  cdc_pkg::w_beat_t  i_wr,
    input  logic              i_clk_r,
    input  logic              r_reset,
    output cdc_pkg::r_beat_t  o_rd
);

    cdc_pkg::lane_word_t [cdc_pkg::LANES-1:0]    wdata;      // Registered write beat
    cdc_pkg::lane_word_t [cdc_pkg::LANES-1:0]    rdata;      // Async RAM outputs
    logic                [ADDR_W-1:0]            waddr;
    logic                [ADDR_W-1:0]            wptr;
    logic                [ADDR_W-1:0]            wptr_sync;  // Read domain copy
    logic [cdc_pkg::LANES-1:0][ADDR_W-1:0]       raddr;

    // ############################
    // Write side
    // ############################

    wr_front #(
        .ADDR_W        (ADDR_W)
    ) i_wr_front (
        .i_clk_w       (i_clk_w),
        .i_reset_async (r_reset),
        .i_wr          (i_wr),
        .o_wdata       (wdata),
        .o_waddr       (waddr),
        .o_wptr        (wptr)
    );

    // ############################
    // Lane memories
    // ############################

    for (genvar lane = 0; lane < cdc_pkg::LANES; lane++) begin : g_lane
        lane_ram #(
            .ADDR_W  (ADDR_W),
            .T       (cdc_pkg::lane_word_t)
        ) i_lane_ram (
            .i_clk_w (i_clk_w),
            .i_waddr (waddr),
            .i_wdata (wdata[lane]),
            .i_raddr (raddr[lane]),
            .o_rdata (rdata[lane])
        );
    end

    // ############################
    // Pointer crossing and read side
    // ############################

    gray_ptr_sync #(
        .ADDR_W  (ADDR_W)
    ) i_gray_ptr_sync (
        .i_clk_w (i_clk_w),
        .i_ptr   (wptr),
        .i_clk_r (i_clk_r),
        .o_ptr   (wptr_sync)
    );

    rd_lane_ctrl #(
        .ADDR_W      (ADDR_W)
    ) i_rd_lane_ctrl (
        .i_clk_r     (i_clk_r),
        .r_reset     (r_reset),
        .i_wptr_sync (wptr_sync),
        .i_rdata     (rdata),
        .o_raddr     (raddr),
        .o_rd        (o_rd)
    );

endmodule

// File: test/tb_cdc_data_sync.sv
// ############################
// Write clock is slower than read clock, so the writer never gets 31 entries ahead
// ############################

module tb_cdc_data_sync;

    localparam int ADDR_W      = 5;
    localparam int BURST       = 40;   // Longer than the RAM depth
    localparam int GAP_N       = 16;
    localparam int NUM_STIM    = BURST + GAP_N;
    localparam int DRAIN_LIMIT = 200;  // Read cycles
    localparam int QUIET_TIME  = 40;

    typedef cdc_pkg::lane_word_t [cdc_pkg::LANES-1:0] beat_data_t;

    // One row of the stimulus table
    typedef struct packed {
        logic       valid;
        logic [7:0] idle;   // Idle write cycles before this entry
        beat_data_t data;
    } stim_t;

    // Tail of the table with mixed gaps and a few entries with valid low
    localparam logic [7:0] GAP_IDLE [GAP_N] = '{
        8'd3, 8'd0, 8'd1, 8'd7, 8'd0, 8'd2, 8'd12, 8'd0,
        8'd5, 8'd1, 8'd0, 8'd9, 8'd4, 8'd0, 8'd2, 8'd20};
    localparam logic GAP_VALID [GAP_N] = '{
        1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1,
        1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1};
    localparam logic [cdc_pkg::LANES-1:0] ALL_LANES = '1;

    logic             i_clk_w = 1'b0;
    logic             i_clk_r = 1'b0;
    logic             r_reset;
    cdc_pkg::w_beat_t i_wr;
    cdc_pkg::r_beat_t o_rd;

    stim_t      stim_table [NUM_STIM];
    beat_data_t exp_q [$];
    int         errors     = 0;
    int         beats_sent = 0;
    int         beats_seen = 0;

    cdc_data_sync #(
        .ADDR_W  (ADDR_W)
    ) i_cdc_data_sync (
        .i_clk_w (i_clk_w),
        .i_wr    (i_wr),
        .i_clk_r (i_clk_r),
        .r_reset (r_reset),
        .o_rd    (o_rd)
    );

    initial begin
        forever #4 i_clk_r = ~i_clk_r;
    end

    initial begin
        forever #5 i_clk_w = ~i_clk_w;
    end

    // ############################
    // Helpers
    // ############################

    task automatic check(input string name, input cdc_pkg::lane_word_t expected,
                         input cdc_pkg::lane_word_t actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Low 16 bits tag entry and lane, so every lane word is distinct
    function automatic cdc_pkg::lane_word_t make_lane_word(input int entry, input int lane);
        logic [95:0] rnd;
        if (entry == 1) begin
            return {49'h1_FFFF_FFFF_FFFF, 8'(entry), 8'(lane)};
        end else if (entry == 2) begin
            return {49'h0, 8'(entry), 8'(lane)};
        end else if (entry % 5 == 0) begin
            return {17'h1_5A5A, 32'(entry) * 32'h0101_0101, 8'(entry), 8'(lane)};
        end else begin
            rnd = {$urandom, $urandom, $urandom};
            return {rnd[48:0], 8'(entry), 8'(lane)};
        end
    endfunction

    task automatic build_table();
        for (int e = 0; e < NUM_STIM; e++) begin
            if (e < BURST) begin
                stim_table[e].valid = 1'b1;  // Back to back burst
                stim_table[e].idle  = 8'd0;
            end else begin
                stim_table[e].valid = GAP_VALID[e - BURST];
                stim_table[e].idle  = GAP_IDLE[e - BURST];
            end
            for (int l = 0; l < cdc_pkg::LANES; l++) begin
                stim_table[e].data[l] = make_lane_word(e, l);
            end
        end
    endtask

    task automatic drive_table();
        for (int e = 0; e < NUM_STIM; e++) begin
            for (int c = 0; c < int'(stim_table[e].idle); c++) begin
                @(posedge i_clk_w);
                #1;
                i_wr.valid = 1'b0;
            end
            @(posedge i_clk_w);
            #1;
            i_wr.valid = stim_table[e].valid;
            i_wr.data  = stim_table[e].data;
            if (stim_table[e].valid) begin
                exp_q.push_back(stim_table[e].data);
                beats_sent++;
            end
        end
        @(posedge i_clk_w);
        #1;
        i_wr.valid = 1'b0;
    endtask

    // ############################
    // Read side checker
    // ############################

    // Outputs move on the rising edge, so sample on the falling one
    always @(negedge i_clk_r) begin
        beat_data_t exp_beat;
        if (o_rd.valid !== '0) begin
            beats_seen++;
            if (exp_q.size() == 0) begin
                $display("Error at %0t: output valid with no written beat outstanding", $time);
                errors++;
            end else begin
                exp_beat = exp_q.pop_front();
                check("o_rd.valid", cdc_pkg::lane_word_t'(ALL_LANES),
                      cdc_pkg::lane_word_t'(o_rd.valid));
                for (int l = 0; l < cdc_pkg::LANES; l++) begin
                    check($sformatf("o_rd.data[%0d]", l), exp_beat[l], o_rd.data[l]);
                end
            end
        end
    end

    // ############################
    // Main sequence
    // ############################

    initial begin
        int wait_cnt;
        i_wr    = '0;
        r_reset = 1'b1;
        void'($urandom(35096));
        build_table();
        repeat (10) @(posedge i_clk_r);
        #1;
        r_reset = 1'b0;
        repeat (4) @(posedge i_clk_w);  // Write domain leaves reset three clocks later
        drive_table();
        wait_cnt = 0;
        while (exp_q.size() != 0 && wait_cnt < DRAIN_LIMIT) begin
            @(posedge i_clk_r);
            wait_cnt++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d written beats never came out of the read side", exp_q.size());
            errors++;
        end
        wait_cnt = 0;
        while (wait_cnt < QUIET_TIME) begin  // Extra beats show up here
            @(posedge i_clk_r);
            wait_cnt++;
        end
        check("beat count", cdc_pkg::lane_word_t'(beats_sent),
              cdc_pkg::lane_word_t'(beats_seen));
        $display("Errors: %0d, beats written: %0d, beats read: %0d",
                 errors, beats_sent, beats_seen);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: cdc_data_sync.f
rtl/cdc_pkg.sv
rtl/wr_front.sv
rtl/lane_ram.sv
rtl/gray_ptr_sync.sv
rtl/rd_lane_ctrl.sv
rtl/cdc_data_sync.sv
test/tb_cdc_data_sync.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_cdc_data_sync
FILELIST  ?= cdc_data_sync.f
LOG       ?= sim.log
FAIL_MSG  := Finished with errors
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "TEST FAILED: run did not end"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf obj_dir $(LOG)
